//--- verilog/shell_consts.svh
////////////////////////////////////////////////////////////////////////////
// Shell constants: PLL reset hold length, Wishbone register map, ID word
// and the PS/2 scan codes of the mapped keys
////////////////////////////////////////////////////////////////////////////
`ifndef SHELL_CONSTS_SVH
`define SHELL_CONSTS_SVH

// PLL reset pulse length in clk_sys cycles
`define SHELL_PLL_HOLD_CYCLES 256

// Host register word addresses
`define SHELL_REG_STATUS  2'd0
`define SHELL_REG_CONTROL 2'd1
`define SHELL_REG_ID      2'd2

`define SHELL_ID_VALUE 32'hCA5E_0100

// Scan codes, set 2, make code only
`define SHELL_KEY_UP    8'h75
`define SHELL_KEY_DOWN  8'h72
`define SHELL_KEY_LEFT  8'h6B
`define SHELL_KEY_RIGHT 8'h74
`define SHELL_KEY_CTRL  8'h14
`define SHELL_KEY_ALT   8'h11
`define SHELL_KEY_SPACE 8'h29
`define SHELL_KEY_1     8'h16
`define SHELL_KEY_2     8'h1E
`define SHELL_KEY_5     8'h2E
`define SHELL_KEY_6     8'h36
`define SHELL_KEY_9     8'h46
`define SHELL_KEY_0     8'h45
`define SHELL_KEY_A     8'h1C
`define SHELL_KEY_S     8'h1B
`define SHELL_KEY_Q     8'h15
`define SHELL_KEY_R     8'h2D
`define SHELL_KEY_F     8'h2B
`define SHELL_KEY_D     8'h23
`define SHELL_KEY_G     8'h34
`define SHELL_KEY_P     8'h4D

`endif

//--- verilog/config_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Configuration types: Wishbone bus, decoded menu options, scandoubler
// mode, reset guard state and the video pixel structs
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package config_pkg;

  // Wishbone classic, host to slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // Menu scandoubler setting, status bits 6..4
  typedef enum logic [2:0] {
    fx_none  = 3'd0,
    fx_hq2x  = 3'd1,
    fx_crt25 = 3'd2,
    fx_crt50 = 3'd3,
    fx_crt75 = 3'd4
  } fx_mode_e;

  typedef struct packed {
    logic       wide;
    logic       rotate;
    logic       flip;
    fx_mode_e   fx;
    logic       compat;
    logic       sprite_en;
    logic       layer0_en;
    logic       layer1_en;
    logic       layer2_en;
    logic       row_scroll_en;
    logic       row_select_en;
    logic [3:0] game_index;
    logic [3:0] offset_x;
    logic [3:0] offset_y;
  } core_options_t;

  typedef enum logic {
    guard_locked_ok,
    guard_holding
  } guard_state_e;

  // Core pixel stream
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    logic       hsync;
    logic       vsync;
    logic       hblank;
    logic       vblank;
  } video_pix_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    logic       hsync;
    logic       vsync;
    logic       hblank;
    logic       vblank;
    logic       de;
  } vga_out_t;

endpackage

`default_nettype wire

//--- verilog/input_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Input types: PS/2 key events, joystick words, key state, player controls
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package input_pkg;

  // Host key event, toggle flips on every new event
  typedef struct packed {
    logic       toggle;
    logic       pressed;
    logic       extended;
    logic [7:0] code;
  } ps2_key_t;

  // Joystick word, bit 0 is right
  typedef struct packed {
    logic [20:0] spare;
    logic        service;
    logic        pause;
    logic        coin;
    logic        start;
    logic [2:0]  buttons;
    logic        up;
    logic        down;
    logic        left;
    logic        right;
  } joystick_t;

  typedef struct packed {
    logic       up;
    logic       down;
    logic       left;
    logic       right;
    logic [2:0] buttons;
    logic       start;
    logic       coin;
    logic       pause;
    logic       service;
  } player_ctrl_t;

  typedef struct packed {
    player_ctrl_t p2;
    player_ctrl_t p1;
  } player_pair_t;

  // One held flag per mapped key
  typedef struct packed {
    logic up, down, left, right;
    logic ctrl, alt, space;
    logic k1, k2, k5, k6, k9, k0;
    logic a, s, q, r, f, d, g, p;
  } key_state_t;

endpackage

`default_nettype wire

//--- verilog/pll_reset_guard.sv
////////////////////////////////////////////////////////////////////////////
// PLL lock loss detector with reset hold counter, and core reset sync
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "shell_consts.svh"

module pll_reset_guard (
  input  wire  clk_sys,
  input  wire  RESET,
  input  wire  pll_locked,
  input  wire  soft_reset,
  output logic pll_reset,
  output logic core_reset
);
  import config_pkg::*;

  localparam int CNT_W = $clog2(`SHELL_PLL_HOLD_CYCLES);

  guard_state_e   state;
  logic           old_locked;
  logic [CNT_W-1:0] hold_cnt;
  logic [1:0]     rst_sync;
  logic           core_cause;

  //////////////////////////////////////////////////////////////////////////
  // Lock loss
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      old_locked <= 1'b0;
      state      <= guard_locked_ok;
      hold_cnt   <= '0;
    end else begin
      old_locked <= pll_locked;
      if (old_locked && !pll_locked) begin
        // Falling lock restarts the hold, even mid-pulse
        state    <= guard_holding;
        hold_cnt <= CNT_W'(`SHELL_PLL_HOLD_CYCLES - 1);
      end else if (state == guard_holding) begin
        if (hold_cnt == '0)
          state <= guard_locked_ok;
        else
          hold_cnt <= hold_cnt - 1'b1;
      end
    end
  end

  assign pll_reset = (state == guard_holding);

  //////////////////////////////////////////////////////////////////////////
  // Core reset, asserted at once by RESET, released through two flops
  //////////////////////////////////////////////////////////////////////////

  assign core_cause = ~pll_locked | soft_reset;

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET)
      rst_sync <= 2'b11;
    else if (core_cause)
      rst_sync <= 2'b11;
    else
      rst_sync <= {rst_sync[0], 1'b0};
  end

  assign core_reset = rst_sync[1];

endmodule

`default_nettype wire

//--- verilog/option_regs.sv
////////////////////////////////////////////////////////////////////////////
// Wishbone classic slave with status, control and ID registers, and the
// decode of the menu status word into core options
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "shell_consts.svh"

module option_regs (
  input  wire                       clk_sys,
  input  wire                       RESET,
  input  wire config_pkg::wb_req_t  wb,
  output config_pkg::wb_rsp_t       wb_rsp,
  output config_pkg::core_options_t options,
  output logic                      soft_reset
);
  import config_pkg::*;

  logic [31:0] status_q;
  logic [31:0] control_q;
  logic [31:0] rdata_q;
  logic        ack_q;
  logic        access;

  // A held strobe is taken every second cycle
  assign access = wb.cyc & wb.stb & ~ack_q;

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      ack_q     <= 1'b0;
      status_q  <= '0;
      control_q <= '0;
    end else begin
      ack_q <= access;
      if (access && wb.we) begin
        for (int i = 0; i < 4; i++) begin
          if (wb.sel[i]) begin
            case (wb.adr)
              `SHELL_REG_STATUS:  status_q[8*i +: 8]  <= wb.dat[8*i +: 8];
              `SHELL_REG_CONTROL: control_q[8*i +: 8] <= wb.dat[8*i +: 8];
              default: ;
            endcase
          end
        end
      end
    end
  end

  // Read data, valid with ack
  always_ff @(posedge clk_sys) begin
    if (access) begin
      case (wb.adr)
        `SHELL_REG_STATUS:  rdata_q <= status_q;
        `SHELL_REG_CONTROL: rdata_q <= control_q;
        `SHELL_REG_ID:      rdata_q <= `SHELL_ID_VALUE;
        default:            rdata_q <= '0;
      endcase
    end
  end

  assign wb_rsp     = '{ack: ack_q, dat: rdata_q};
  assign soft_reset = control_q[0];

  //////////////////////////////////////////////////////////////////////////
  // Menu decode, debug bits are disables
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    options               = '0;
    options.wide          = status_q[1];
    options.rotate        = status_q[2];
    options.flip          = status_q[3];
    options.fx            = fx_mode_e'(status_q[6:4]);
    options.compat        = status_q[7];
    options.sprite_en     = ~status_q[10];
    options.layer0_en     = ~status_q[11];
    options.layer1_en     = ~status_q[12];
    options.layer2_en     = ~status_q[13];
    options.row_scroll_en = ~status_q[14];
    options.row_select_en = ~status_q[15];
    options.game_index    = status_q[19:16];
    options.offset_x      = status_q[27:24];
    options.offset_y      = status_q[31:28];
  end

endmodule

`default_nettype wire

//--- verilog/input_mapper.sv
////////////////////////////////////////////////////////////////////////////
// PS/2 key latch and merge of keys with joysticks into player controls
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "shell_consts.svh"

module input_mapper (
  input  wire                       clk_sys,
  input  wire                       core_reset,
  input  wire input_pkg::ps2_key_t  ps2_key,
  input  wire input_pkg::joystick_t joystick_0,
  input  wire input_pkg::joystick_t joystick_1,
  output input_pkg::player_pair_t   players
);
  import input_pkg::*;

  key_state_t   keys;
  logic         old_toggle;
  player_ctrl_t p1_keys;
  player_ctrl_t p2_keys;

  function automatic player_ctrl_t joy_ctrl(input joystick_t j);
    return '{up: j.up, down: j.down, left: j.left, right: j.right,
             buttons: j.buttons, start: j.start, coin: j.coin,
             pause: j.pause, service: j.service};
  endfunction

  // Follows the toggle bit at all times, so a release sees no stale event
  always_ff @(posedge clk_sys) begin
    old_toggle <= ps2_key.toggle;
  end

  always_ff @(posedge clk_sys or posedge core_reset) begin
    if (core_reset) begin
      keys <= '0;
    end else if (old_toggle != ps2_key.toggle) begin
      case (ps2_key.code)
        `SHELL_KEY_UP:    keys.up    <= ps2_key.pressed;
        `SHELL_KEY_DOWN:  keys.down  <= ps2_key.pressed;
        `SHELL_KEY_LEFT:  keys.left  <= ps2_key.pressed;
        `SHELL_KEY_RIGHT: keys.right <= ps2_key.pressed;
        `SHELL_KEY_CTRL:  keys.ctrl  <= ps2_key.pressed;
        `SHELL_KEY_ALT:   keys.alt   <= ps2_key.pressed;
        `SHELL_KEY_SPACE: keys.space <= ps2_key.pressed;
        `SHELL_KEY_1:     keys.k1    <= ps2_key.pressed;
        `SHELL_KEY_2:     keys.k2    <= ps2_key.pressed;
        `SHELL_KEY_5:     keys.k5    <= ps2_key.pressed;
        `SHELL_KEY_6:     keys.k6    <= ps2_key.pressed;
        `SHELL_KEY_9:     keys.k9    <= ps2_key.pressed;
        `SHELL_KEY_0:     keys.k0    <= ps2_key.pressed;
        `SHELL_KEY_A:     keys.a     <= ps2_key.pressed;
        `SHELL_KEY_S:     keys.s     <= ps2_key.pressed;
        `SHELL_KEY_Q:     keys.q     <= ps2_key.pressed;
        `SHELL_KEY_R:     keys.r     <= ps2_key.pressed;
        `SHELL_KEY_F:     keys.f     <= ps2_key.pressed;
        `SHELL_KEY_D:     keys.d     <= ps2_key.pressed;
        `SHELL_KEY_G:     keys.g     <= ps2_key.pressed;
        `SHELL_KEY_P:     keys.p     <= ps2_key.pressed;
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Keyboard layout per player
  //////////////////////////////////////////////////////////////////////////

  assign p1_keys = '{up: keys.up, down: keys.down, left: keys.left,
                     right: keys.right,
                     buttons: {keys.space, keys.alt, keys.ctrl},
                     start: keys.k1, coin: keys.k5, pause: keys.p,
                     service: keys.k9};

  // Player 2 has no pause key
  assign p2_keys = '{up: keys.r, down: keys.f, left: keys.d, right: keys.g,
                     buttons: {keys.q, keys.s, keys.a},
                     start: keys.k2, coin: keys.k6, pause: 1'b0,
                     service: keys.k0};

  always_ff @(posedge clk_sys or posedge core_reset) begin
    if (core_reset) begin
      players <= '0;
    end else begin
      players.p1 <= p1_keys | joy_ctrl(joystick_0);
      players.p2 <= p2_keys | joy_ctrl(joystick_1);
    end
  end

endmodule

`default_nettype wire

//--- verilog/video_out_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// VGA output stage: pixel register with DE and blanking, scanline level
// and aspect ratio
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module video_out_ctrl (
  input  wire                           clk_sys,
  input  wire                           core_reset,
  input  wire                           ce_pix,
  input  wire config_pkg::video_pix_t   video_in,
  input  wire config_pkg::core_options_t options,
  output config_pkg::vga_out_t          vga,
  output logic [1:0]                    vga_sl,
  output logic [12:0]                   video_arx,
  output logic [12:0]                   video_ary
);
  import config_pkg::*;

  logic       de_next;
  logic [2:0] sl_next;

  assign de_next = ~(video_in.hblank | video_in.vblank);

  always_ff @(posedge clk_sys or posedge core_reset) begin
    if (core_reset) begin
      vga <= '0;
    end else if (ce_pix) begin
      // Black outside the active area
      vga.r      <= de_next ? video_in.r : 8'd0;
      vga.g      <= de_next ? video_in.g : 8'd0;
      vga.b      <= de_next ? video_in.b : 8'd0;
      vga.hsync  <= video_in.hsync;
      vga.vsync  <= video_in.vsync;
      vga.hblank <= video_in.hblank;
      vga.vblank <= video_in.vblank;
      vga.de     <= de_next;
    end
  end

  // CRT 25/50/75 map to scanline levels 1..3
  assign sl_next = (options.fx == fx_none) ? 3'd0 : 3'(options.fx) - 3'd1;

  always_ff @(posedge clk_sys) begin
    vga_sl <= sl_next[1:0];
    if (options.wide) begin
      video_arx <= 13'd16;
      video_ary <= 13'd9;
    end else if (options.rotate) begin
      video_arx <= 13'd3;
      video_ary <= 13'd4;
    end else begin
      video_arx <= 13'd4;
      video_ary <= 13'd3;
    end
  end

endmodule

`default_nettype wire

//--- verilog/arcade_shell_top.sv
////////////////////////////////////////////////////////////////////////////
// Arcade board shell top: clock and reset, host I/O, video, controls
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module arcade_shell_top (
  input  wire                       clk_sys,
  input  wire                       RESET,
  input  wire                       pll_locked,
  input  wire                       ce_pix,
  input  wire config_pkg::wb_req_t  wb,
  input  wire input_pkg::ps2_key_t  ps2_key,
  input  wire input_pkg::joystick_t joystick_0,
  input  wire input_pkg::joystick_t joystick_1,
  input  wire config_pkg::video_pix_t video_in,
  output config_pkg::wb_rsp_t       wb_rsp,
  output logic                      pll_reset,
  output logic                      core_reset,
  output config_pkg::core_options_t options,
  output input_pkg::player_pair_t   players,
  output config_pkg::vga_out_t      vga,
  output logic [1:0]                vga_sl,
  output logic [12:0]               video_arx,
  output logic [12:0]               video_ary
);

  // Control bit 0 from the host
  wire soft_reset;

  //////////////////////////////////////////////////////////////////////////
  // Clock and reset
  //////////////////////////////////////////////////////////////////////////

  pll_reset_guard u_reset_guard (
    .clk_sys    (clk_sys),
    .RESET      (RESET),
    .pll_locked (pll_locked),
    .soft_reset (soft_reset),
    .pll_reset  (pll_reset),
    .core_reset (core_reset)
  );

  //////////////////////////////////////////////////////////////////////////
  // Host I/O
  //////////////////////////////////////////////////////////////////////////

  option_regs u_option_regs (
    .clk_sys    (clk_sys),
    .RESET      (RESET),
    .wb         (wb),
    .wb_rsp     (wb_rsp),
    .options    (options),
    .soft_reset (soft_reset)
  );

  //////////////////////////////////////////////////////////////////////////
  // Video
  //////////////////////////////////////////////////////////////////////////

  video_out_ctrl u_video_out (
    .clk_sys    (clk_sys),
    .core_reset (core_reset),
    .ce_pix     (ce_pix),
    .video_in   (video_in),
    .options    (options),
    .vga        (vga),
    .vga_sl     (vga_sl),
    .video_arx  (video_arx),
    .video_ary  (video_ary)
  );

  //////////////////////////////////////////////////////////////////////////
  // Controls
  //////////////////////////////////////////////////////////////////////////

  input_mapper u_input_mapper (
    .clk_sys    (clk_sys),
    .core_reset (core_reset),
    .ps2_key    (ps2_key),
    .joystick_0 (joystick_0),
    .joystick_1 (joystick_1),
    .players    (players)
  );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
////////////////////////////////////////////////////////////////////////////
// Testbench clock of 10 ns and a power-on reset held for two cycles
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk_sys,
  output logic RESET
);

  initial begin
    clk_sys = 1'b0;
    forever #5 clk_sys = ~clk_sys;
  end

  initial begin
    RESET = 1'b1;
    repeat (2) @(posedge clk_sys);
    RESET <= 1'b0;
  end

endmodule

`default_nettype wire

//--- verification/tb_arcade_shell.sv
////////////////////////////////////////////////////////////////////////////
// Arcade shell testbench for the PLL reset guard, host registers, option
// decode, player controls, video output and soft reset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "shell_consts.svh"

module tb_arcade_shell;
  import config_pkg::*;
  import input_pkg::*;

  // Mapped scan codes and the bit each drives in {p2, p1}
  localparam logic [7:0] KEY_CODES [21] = '{
    `SHELL_KEY_UP, `SHELL_KEY_DOWN, `SHELL_KEY_LEFT, `SHELL_KEY_RIGHT,
    `SHELL_KEY_CTRL, `SHELL_KEY_ALT, `SHELL_KEY_SPACE, `SHELL_KEY_1,
    `SHELL_KEY_5, `SHELL_KEY_P, `SHELL_KEY_9,
    `SHELL_KEY_R, `SHELL_KEY_F, `SHELL_KEY_D, `SHELL_KEY_G,
    `SHELL_KEY_A, `SHELL_KEY_S, `SHELL_KEY_Q, `SHELL_KEY_2, `SHELL_KEY_6, `SHELL_KEY_0
  };
  localparam int KEY_BITS [21] = '{
    10, 9, 8, 7, 4, 5, 6, 3, 2, 1, 0,
    21, 20, 19, 18, 15, 16, 17, 14, 13, 11
  };

  logic          clk_sys;
  logic          RESET;
  logic          pll_locked;
  logic          ce_pix;
  wb_req_t       wb;
  ps2_key_t      ps2_key;
  joystick_t     joystick_0;
  joystick_t     joystick_1;
  video_pix_t    video_in;
  wb_rsp_t       wb_rsp;
  logic          pll_reset;
  logic          core_reset;
  core_options_t options;
  player_pair_t  players;
  vga_out_t      vga;
  logic [1:0]    vga_sl;
  logic [12:0]   video_arx;
  logic [12:0]   video_ary;

  logic [31:0]   lcg_state = 32'h7b088b84;
  logic [21:0]   key_model;

  tb_clock_gen u_clock_gen (
    .clk_sys (clk_sys),
    .RESET   (RESET)
  );

  arcade_shell_top u_dut (
    .clk_sys    (clk_sys),
    .RESET      (RESET),
    .pll_locked (pll_locked),
    .ce_pix     (ce_pix),
    .wb         (wb),
    .ps2_key    (ps2_key),
    .joystick_0 (joystick_0),
    .joystick_1 (joystick_1),
    .video_in   (video_in),
    .wb_rsp     (wb_rsp),
    .pll_reset  (pll_reset),
    .core_reset (core_reset),
    .options    (options),
    .players    (players),
    .vga        (vga),
    .vga_sl     (vga_sl),
    .video_arx  (video_arx),
    .video_ary  (video_ary)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic value_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    $display("Something failed");
    $fatal(1, "wrong value");
  endtask

  task automatic timeout_error(input string what);
    $display("Gave up waiting for %s, the DUT did not respond in time", what);
    $display("Something failed");
    $fatal(1, "timeout");
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Joystick word to up, down, left, right, buttons, start, coin, pause, service
  function automatic logic [10:0] joy_to_ctrl(input logic [31:0] j);
    return {j[3], j[2], j[1], j[0], j[6:4], j[7], j[8], j[9], j[10]};
  endfunction

  function automatic core_options_t decode_status(input logic [31:0] s);
    core_options_t o;
    o               = '0;
    o.wide          = s[1];
    o.rotate        = s[2];
    o.flip          = s[3];
    o.fx            = fx_mode_e'(s[6:4]);
    o.compat        = s[7];
    // Debug bits are disables and the core wants enables
    o.sprite_en     = !s[10];
    o.layer0_en     = !s[11];
    o.layer1_en     = !s[12];
    o.layer2_en     = !s[13];
    o.row_scroll_en = !s[14];
    o.row_select_en = !s[15];
    o.game_index    = s[19:16];
    o.offset_x      = s[27:24];
    o.offset_y      = s[31:28];
    return o;
  endfunction

  task automatic bus_access(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, output logic [31:0] rdata);
    int samples;
    samples = 0;
    @(posedge clk_sys);
    wb <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
    do begin
      @(negedge clk_sys);
      samples++;
      if (samples > 8)
        timeout_error("a Wishbone ack");
    end while (!wb_rsp.ack);
    // First sample comes before the edge that takes the request
    assert (samples == 2) else value_error("ack not one cycle after the strobe");
    rdata = wb_rsp.dat;
    @(posedge clk_sys);
    wb <= '0;
  endtask

  task automatic write_reg(input logic [1:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel);
    logic [31:0] ignored;
    bus_access(1'b1, adr, dat, sel, ignored);
  endtask

  task automatic read_reg(input logic [1:0] adr, output logic [31:0] dat);
    bus_access(1'b0, adr, 32'd0, 4'hF, dat);
  endtask

  task automatic send_key(input int idx, input logic pressed);
    @(posedge clk_sys);
    ps2_key <= '{toggle: !ps2_key.toggle, pressed: pressed, extended: 1'b0,
                 code: KEY_CODES[idx]};
    key_model[KEY_BITS[idx]] = pressed;
  endtask

  task automatic players_settle(input logic [21:0] exp, input int max_edges,
                                input string what);
    int edges;
    edges = 0;
    forever begin
      @(negedge clk_sys);
      if (players == exp)
        break;
      edges++;
      assert (edges <= max_edges)
        else value_error($sformatf("%s: players %h, expected %h", what, players, exp));
    end
  endtask

  task automatic core_reset_settle(input logic level, input int max_edges,
                                   input string what);
    int edges;
    edges = 0;
    forever begin
      @(negedge clk_sys);
      if (core_reset == level)
        break;
      edges++;
      assert (edges <= max_edges)
        else value_error($sformatf("%s: core_reset not %0b in time", what, level));
    end
  endtask

  task automatic check_decode(input logic [31:0] s);
    core_options_t exp;
    logic [2:0]    sl;
    logic [12:0]   arx;
    logic [12:0]   ary;
    exp = decode_status(s);
    sl  = (s[6:4] == 3'd0) ? 3'd0 : s[6:4] - 3'd1;
    if (s[1]) begin
      arx = 13'd16;
      ary = 13'd9;
    end else if (s[2]) begin
      arx = 13'd3;
      ary = 13'd4;
    end else begin
      arx = 13'd4;
      ary = 13'd3;
    end
    @(negedge clk_sys);
    assert (options == exp)
      else value_error($sformatf("options %h, expected %h", options, exp));
    assert (vga_sl == sl[1:0])
      else value_error($sformatf("vga_sl %0d, expected %0d", vga_sl, sl[1:0]));
    assert (video_arx == arx && video_ary == ary)
      else value_error($sformatf("aspect %0d:%0d, expected %0d:%0d",
                                 video_arx, video_ary, arx, ary));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Protocol checks
  ////////////////////////////////////////////////////////////////////////////

  assert property (@(posedge clk_sys) disable iff (RESET) wb_rsp.ack |=> !wb_rsp.ack)
    else value_error("ack held for more than one cycle");

  assert property (@(posedge clk_sys)
                   !vga.de |-> (vga.r == 8'd0 && vga.g == 8'd0 && vga.b == 8'd0))
    else value_error("rgb not black outside the active area");

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    logic [31:0] val;
    logic [31:0] rnd;
    logic [31:0] pix;
    logic [21:0] exp_players;
    int          n;
    int          idx;
    vga_out_t    vga_exp;
    logic        exp_valid;
    logic        ce_prev;
    video_pix_t  pix_prev;
    video_pix_t  pix_new;

    pll_locked = 1'b1;
    ce_pix     = 1'b0;
    wb         = '0;
    ps2_key    = '0;
    joystick_0 = '0;
    joystick_1 = '0;
    video_in   = '0;
    key_model  = '0;

    n = 0;
    while (RESET) begin
      @(negedge clk_sys);
      n++;
      if (n > 10)
        timeout_error("the end of the power-on reset");
    end
    core_reset_settle(1'b0, 4, "power-on release");
    assert (!pll_reset && options == decode_status(32'd0))
      else value_error("reset values of pll_reset or options");

    // PLL lock loss and the hold pulse
    @(posedge clk_sys);
    pll_locked <= 1'b0;
    @(negedge clk_sys);
    assert (!pll_reset) else value_error("pll_reset before the lock loss was seen");
    @(negedge clk_sys);
    n = 0;
    while (pll_reset) begin
      assert (core_reset) else value_error("core_reset low while the PLL is unlocked");
      n++;
      if (n > 2 * `SHELL_PLL_HOLD_CYCLES)
        timeout_error("the end of the PLL reset pulse");
      @(negedge clk_sys);
    end
    assert (n == `SHELL_PLL_HOLD_CYCLES)
      else value_error($sformatf("pll_reset held %0d cycles", n));
    @(posedge clk_sys);
    pll_locked <= 1'b1;
    repeat (2) begin
      @(negedge clk_sys);
      assert (core_reset) else value_error("core_reset released too early");
    end
    @(negedge clk_sys);
    assert (!core_reset) else value_error("core_reset not released after the lock");

    // Register access, byte lanes, ID and an unmapped word
    val = next_rand();
    write_reg(`SHELL_REG_STATUS, val, 4'hF);
    read_reg(`SHELL_REG_STATUS, rd);
    assert (rd == val) else value_error($sformatf("status %h, expected %h", rd, val));
    rnd = next_rand();
    write_reg(`SHELL_REG_STATUS, rnd, 4'b0101);
    val = {val[31:24], rnd[23:16], val[15:8], rnd[7:0]};
    read_reg(`SHELL_REG_STATUS, rd);
    assert (rd == val) else value_error($sformatf("byte write %h, expected %h", rd, val));
    read_reg(`SHELL_REG_ID, rd);
    assert (rd == `SHELL_ID_VALUE) else value_error($sformatf("ID %h", rd));
    write_reg(`SHELL_REG_ID, next_rand(), 4'hF);
    read_reg(`SHELL_REG_ID, rd);
    assert (rd == `SHELL_ID_VALUE) else value_error($sformatf("ID %h after write", rd));
    read_reg(2'd3, rd);
    assert (rd == 32'd0) else value_error($sformatf("unmapped word read %h", rd));

    // Decode for every wide and rotate pair and each fx mode
    for (int i = 0; i < 8; i++) begin
      val      = next_rand();
      val[2:1] = i[1:0];
      val[6:4] = 3'(i % 5);
      write_reg(`SHELL_REG_STATUS, val, 4'hF);
      check_decode(val);
    end

    // Key presses and releases
    for (int i = 0; i < 16; i++) begin
      idx = (next_rand() >> 16) % 32'd21;
      send_key(idx, !key_model[KEY_BITS[idx]]);
      players_settle(key_model, 2, "key event");
    end
    idx = (next_rand() >> 16) % 32'd21;
    @(posedge clk_sys);
    ps2_key <= '{toggle: ps2_key.toggle, pressed: !key_model[KEY_BITS[idx]],
                 extended: 1'b0, code: KEY_CODES[idx]};
    repeat (4) begin
      @(negedge clk_sys);
      assert (players == key_model) else value_error("key event without a toggle took effect");
    end

    // Joysticks OR into the keys
    rnd = next_rand();
    @(posedge clk_sys);
    joystick_0 <= {21'd0, rnd[10:0]};
    joystick_1 <= {21'd0, rnd[26:16]};
    exp_players = key_model | {joy_to_ctrl({21'd0, rnd[26:16]}),
                               joy_to_ctrl({21'd0, rnd[10:0]})};
    players_settle(exp_players, 1, "joystick change");
    @(posedge clk_sys);
    joystick_0 <= '0;
    joystick_1 <= '0;
    players_settle(key_model, 1, "joystick release");

    // Video stream where the model trails the drive by one edge
    exp_valid = 1'b0;
    ce_prev   = 1'b0;
    pix_prev  = '0;
    vga_exp   = '0;
    for (int i = 0; i < 60; i++) begin
      rnd     = next_rand();
      pix     = next_rand();
      pix_new = '{r: pix[7:0], g: pix[15:8], b: pix[23:16], hsync: pix[24],
                  vsync: pix[25], hblank: rnd[21], vblank: rnd[22]};
      @(posedge clk_sys);
      ce_pix   <= rnd[20];
      video_in <= pix_new;
      if (ce_prev) begin
        vga_exp = {pix_prev, !(pix_prev.hblank || pix_prev.vblank)};
        if (!vga_exp.de)
          {vga_exp.r, vga_exp.g, vga_exp.b} = 24'd0;
        exp_valid = 1'b1;
      end
      @(negedge clk_sys);
      if (exp_valid) begin
        assert (vga == vga_exp)
          else value_error($sformatf("vga %h, expected %h", vga, vga_exp));
      end
      ce_prev  = rnd[20];
      pix_prev = pix_new;
    end
    @(posedge clk_sys);
    ce_pix <= 1'b0;

    // Soft reset from control bit 0
    send_key(0, 1'b1);
    players_settle(key_model, 2, "key before soft reset");
    write_reg(`SHELL_REG_CONTROL, 32'd1, 4'hF);
    core_reset_settle(1'b1, 2, "soft reset");
    key_model = '0;
    players_settle(key_model, 2, "keys cleared by soft reset");
    write_reg(`SHELL_REG_CONTROL, 32'd0, 4'hF);
    core_reset_settle(1'b0, 4, "soft reset release");
    repeat (3) begin
      @(negedge clk_sys);
      assert (players == 22'd0 && !pll_reset)
        else value_error("keys or pll_reset after the soft reset");
    end

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verilog
verilog/config_pkg.sv
verilog/input_pkg.sv
verilog/pll_reset_guard.sv
verilog/option_regs.sv
verilog/input_mapper.sv
verilog/video_out_ctrl.sv
verilog/arcade_shell_top.sv
verification/tb_clock_gen.sv
verification/tb_arcade_shell.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the arcade shell testbench with Verilator and run it.
# The simulator's exit status tells pass or fail.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
  --top-module tb_arcade_shell \
  -f flist.f \
  -o tb_arcade_shell

./obj_dir/tb_arcade_shell
